// File: run.sh
#!/bin/sh
# Build and run the secure subsystem testbench with Verilator
set -e

verilator --binary -j 0 -f src.f --top-module tb_secure_subsystem -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

# Fails the script unless the pass line is present
echo "$out" | grep -q "^STATUS: PASS$"

// File: src.f
+incdir+src
+incdir+verif
src/ss_pkg.sv
src/ss_sync.sv
src/ss_err_slave.sv
src/ss_isolate.sv
src/secure_subsystem_wrap.sv
verif/secure_subsystem_properties.sv
verif/tb_secure_subsystem.sv

// File: src/secure_subsystem_wrap.sv
// Secure subsystem outer wrapper
// Core reset and input synchronisation, isolation of the outbound bus port

module secure_subsystem_wrap (
   input  logic            clk_i,
   input  logic            arst_n_i,
   input  logic            test_enable_i,
   input  logic            fetch_en_i,
   input  logic            irq_i,
   input  logic            isolate_i,
   // Core controls
   output logic            core_rst_n_o,
   output logic            core_fetch_en_o,
   output logic            core_irq_o,
   output logic            isolated_o,
   // Core side bus port
   input  logic            slv_req_valid_i,
   input  ss_pkg::ss_req_t slv_req_i,
   output logic            slv_req_ready_o,
   output logic            slv_rsp_valid_o,
   output ss_pkg::ss_rsp_t slv_rsp_o,
   input  logic            slv_rsp_ready_i,
   // Outbound bus port
   output logic            mst_req_valid_o,
   output ss_pkg::ss_req_t mst_req_o,
   input  logic            mst_req_ready_i,
   input  logic            mst_rsp_valid_i,
   input  ss_pkg::ss_rsp_t mst_rsp_i,
   output logic            mst_rsp_ready_o
);

   logic isolate_sync;

   ss_sync u_sync (
      .clk_i         ( clk_i           ),
      .arst_n_i      ( arst_n_i        ),
      .test_enable_i ( test_enable_i   ),
      .fetch_en_i    ( fetch_en_i      ),
      .irq_i         ( irq_i           ),
      .isolate_i     ( isolate_i       ),
      .rst_n_o       ( core_rst_n_o    ),
      .fetch_en_o    ( core_fetch_en_o ),
      .irq_o         ( core_irq_o      ),
      .isolate_o     ( isolate_sync    )
   );

   ss_isolate #(
      .req_t ( ss_pkg::ss_req_t ),
      .rsp_t ( ss_pkg::ss_rsp_t )
   ) u_isolate (
      .clk_i           ( clk_i           ),
      .arst_n_i        ( arst_n_i        ),
      .isolate_i       ( isolate_sync    ),
      .isolated_o      ( isolated_o      ),
      .slv_req_valid_i ( slv_req_valid_i ),
      .slv_req_i       ( slv_req_i       ),
      .slv_req_ready_o ( slv_req_ready_o ),
      .slv_rsp_valid_o ( slv_rsp_valid_o ),
      .slv_rsp_o       ( slv_rsp_o       ),
      .slv_rsp_ready_i ( slv_rsp_ready_i ),
      .mst_req_valid_o ( mst_req_valid_o ),
      .mst_req_o       ( mst_req_o       ),
      .mst_req_ready_i ( mst_req_ready_i ),
      .mst_rsp_valid_i ( mst_rsp_valid_i ),
      .mst_rsp_i       ( mst_rsp_i       ),
      .mst_rsp_ready_o ( mst_rsp_ready_o )
   );

endmodule

// File: src/ss_cfg.svh
// Secure subsystem wrapper configuration
// Synchroniser depth, outstanding limit and bus field widths

`ifndef SS_CFG_SVH
`define SS_CFG_SVH

// Flops per synchronised input and in the reset chain
`define SS_SYNC_STAGES 3

// Outstanding downstream transactions
`define SS_MAX_PENDING 8
`define SS_PENDING_W   4

// Bus fields
`define SS_ADDR_W 32
`define SS_DATA_W 32
`define SS_ID_W   4

`endif

// File: src/ss_err_slave.sv
// Local bus terminator
// Answers every request with an error response carrying its id

module ss_err_slave #(
   parameter type req_t = ss_pkg::ss_req_t,
   parameter type rsp_t = ss_pkg::ss_rsp_t
) (
   input  logic clk_i,
   input  logic arst_n_i,
   input  logic req_valid_i,
   input  req_t req_i,
   output logic req_ready_o,
   output logic rsp_valid_o,
   output rsp_t rsp_o,
   input  logic rsp_ready_i
);

   logic busy_q;
   rsp_t rsp_d;
   rsp_t rsp_q;

   // Zero data, id echoed, error set
   always_comb begin
      rsp_d     = '0;
      rsp_d.id  = req_i.id;
      rsp_d.err = 1'b1;
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_q <= 1'b0;
      end else if (!busy_q && req_valid_i) begin
         busy_q <= 1'b1;
      end else if (busy_q && rsp_ready_i) begin
         busy_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!busy_q && req_valid_i) begin
         rsp_q <= rsp_d;
      end
   end

   // Single outstanding request
   assign req_ready_o = ~busy_q;
   assign rsp_valid_o = busy_q;
   assign rsp_o       = rsp_q;

endmodule

// File: src/ss_isolate.sv
// Bus isolation gate
// Forwards while open, drains outstanding transactions on isolate,
// then terminates new requests locally with error responses

`include "ss_cfg.svh"

module ss_isolate #(
   parameter type req_t = ss_pkg::ss_req_t,
   parameter type rsp_t = ss_pkg::ss_rsp_t
) (
   input  logic clk_i,
   input  logic arst_n_i,
   input  logic isolate_i,
   output logic isolated_o,
   // Upstream port
   input  logic slv_req_valid_i,
   input  req_t slv_req_i,
   output logic slv_req_ready_o,
   output logic slv_rsp_valid_o,
   output rsp_t slv_rsp_o,
   input  logic slv_rsp_ready_i,
   // Downstream port
   output logic mst_req_valid_o,
   output req_t mst_req_o,
   input  logic mst_req_ready_i,
   input  logic mst_rsp_valid_i,
   input  rsp_t mst_rsp_i,
   output logic mst_rsp_ready_o
);

   localparam logic [`SS_PENDING_W-1:0] pend_max = (`SS_PENDING_W)'(`SS_MAX_PENDING);

   logic [`SS_PENDING_W-1:0] pending_q;
   logic [`SS_PENDING_W-1:0] pending_d;
   logic                     isolated_q;
   logic                     hold_q;
   logic                     fwd;
   logic                     term;
   logic                     below_max;
   logic                     mst_req_hs;
   logic                     mst_rsp_hs;

   logic err_req_valid;
   logic err_req_ready;
   logic err_rsp_valid;
   rsp_t err_rsp;

   // A request already offered downstream stays offered until taken
   assign fwd       = !isolated_q && (!isolate_i || hold_q);
   assign term      = isolated_q && isolate_i;
   assign below_max = (pending_q != pend_max);

   assign mst_req_valid_o = slv_req_valid_i && fwd && below_max;
   assign mst_req_o       = slv_req_i;
   assign err_req_valid   = slv_req_valid_i && term;

   // Stalls while draining and during release
   always_comb begin
      if (fwd) begin
         slv_req_ready_o = mst_req_ready_i && below_max;
      end else if (term) begin
         slv_req_ready_o = err_req_ready;
      end else begin
         slv_req_ready_o = 1'b0;
      end
   end

   // Terminator response has priority, downstream waits behind it
   assign slv_rsp_valid_o = err_rsp_valid || mst_rsp_valid_i;
   assign slv_rsp_o       = err_rsp_valid ? err_rsp : mst_rsp_i;
   assign mst_rsp_ready_o = slv_rsp_ready_i && !err_rsp_valid;

   assign mst_req_hs = mst_req_valid_o && mst_req_ready_i;
   assign mst_rsp_hs = mst_rsp_valid_i && mst_rsp_ready_o;

   always_comb begin
      pending_d = pending_q;
      if (mst_req_hs && !mst_rsp_hs) begin
         pending_d = pending_q + 1'b1;
      end else if (!mst_req_hs && mst_rsp_hs) begin
         pending_d = pending_q - 1'b1;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pending_q  <= '0;
         hold_q     <= 1'b0;
         isolated_q <= 1'b1;
      end else begin
         pending_q <= pending_d;
         hold_q    <= mst_req_valid_o && !mst_req_ready_i;
         if (!isolate_i) begin
            isolated_q <= 1'b0;
         end else if (pending_q == '0 && !hold_q) begin
            isolated_q <= 1'b1;
         end
      end
   end

   assign isolated_o = isolated_q;

   ss_err_slave #(
      .req_t ( req_t ),
      .rsp_t ( rsp_t )
   ) u_err_slave (
      .clk_i       ( clk_i           ),
      .arst_n_i    ( arst_n_i        ),
      .req_valid_i ( err_req_valid   ),
      .req_i       ( slv_req_i       ),
      .req_ready_o ( err_req_ready   ),
      .rsp_valid_o ( err_rsp_valid   ),
      .rsp_o       ( err_rsp         ),
      .rsp_ready_i ( slv_rsp_ready_i )
   );

endmodule

// File: src/ss_pkg.sv
// Secure subsystem bus payload types
// One request and one response channel

`include "ss_cfg.svh"

package ss_pkg;

   // 69 bits
   typedef struct packed {
      logic [`SS_ADDR_W-1:0] addr;
      logic [`SS_DATA_W-1:0] wdata;
      logic                  write;
      logic [`SS_ID_W-1:0]   id;
   } ss_req_t;

   // 37 bits
   typedef struct packed {
      logic [`SS_DATA_W-1:0] rdata;
      logic [`SS_ID_W-1:0]   id;
      logic                  err;
   } ss_rsp_t;

endpackage

// File: src/ss_sync.sv
// Reset generator and input synchroniser bank
// Core reset released after a flop chain, bypassed in test mode

`include "ss_cfg.svh"

module ss_sync (
   input  logic clk_i,
   input  logic arst_n_i,
   input  logic test_enable_i,
   input  logic fetch_en_i,
   input  logic irq_i,
   input  logic isolate_i,
   output logic rst_n_o,
   output logic fetch_en_o,
   output logic irq_o,
   output logic isolate_o
);

   localparam int unsigned stages = `SS_SYNC_STAGES;

   // Bit order: isolate, irq, fetch enable
   localparam logic [2:0] in_rst_val = 3'b100;

   logic [stages-1:0]      rst_q;
   logic [2:0]             in_d;
   logic [2:0][stages-1:0] in_q;

   // Falls with the async reset, rises after the chain fills with ones
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rst_q <= '0;
      end else begin
         rst_q <= {rst_q[stages-2:0], 1'b1};
      end
   end

   assign rst_n_o = test_enable_i ? arst_n_i : rst_q[stages-1];

   assign in_d = {isolate_i, irq_i, fetch_en_i};

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < 3; i++) begin
            in_q[i] <= {stages{in_rst_val[i]}};
         end
      end else begin
         for (int i = 0; i < 3; i++) begin
            in_q[i] <= {in_q[i][stages-2:0], in_d[i]};
         end
      end
   end

   assign fetch_en_o = in_q[0][stages-1];
   assign irq_o      = in_q[1][stages-1];
   // Starts high so the bus port comes out of reset isolated
   assign isolate_o  = in_q[2][stages-1];

endmodule

// File: verif/secure_subsystem_properties.sv
// Bus protocol and isolation properties for the secure subsystem wrapper
// Bound to the top level from the testbench

module ss_properties (
   input logic            clk_i,
   input logic            arst_n_i,
   input logic            isolated_o,
   input logic            slv_rsp_valid_o,
   input logic            slv_rsp_ready_i,
   input ss_pkg::ss_rsp_t slv_rsp_o,
   input logic            mst_req_valid_o,
   input logic            mst_req_ready_i,
   input ss_pkg::ss_req_t mst_req_o
);

   // Valid held until ready, upstream response and downstream request
   a_slv_rsp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      slv_rsp_valid_o && !slv_rsp_ready_i |=> slv_rsp_valid_o)
      else $error("slv_rsp_valid_o dropped before slv_rsp_ready_i");

   a_mst_req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      mst_req_valid_o && !mst_req_ready_i |=> mst_req_valid_o)
      else $error("mst_req_valid_o dropped before mst_req_ready_i");

   // Payloads stable while stalled
   a_slv_rsp_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      slv_rsp_valid_o && !slv_rsp_ready_i |=> $stable(slv_rsp_o))
      else $error("slv_rsp_o changed while stalled");

   a_mst_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      mst_req_valid_o && !mst_req_ready_i |=> $stable(mst_req_o))
      else $error("mst_req_o changed while stalled");

   a_no_fwd_isolated: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      isolated_o |-> !mst_req_valid_o)
      else $error("mst_req_valid_o high while isolated");

endmodule

// File: verif/tb_secure_subsystem_tests.svh
// Directed tests for the secure subsystem wrapper
// Included into the testbench module

`ifndef TB_SECURE_SUBSYSTEM_TESTS_SVH
`define TB_SECURE_SUBSYSTEM_TESTS_SVH

task automatic check_bit(input string name, input logic got, input logic exp);
   checks++;
   if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      errors++;
   end
endtask

task automatic test_done(input string name, input int err_before);
   $display("%s: %s", name, (errors == err_before) ? "passed" : "failed");
endtask

function automatic ss_pkg::ss_req_t random_req();
   ss_pkg::ss_req_t r;
   logic [31:0]     w;
   r.addr  = $urandom();
   r.wdata = $urandom();
   w       = $urandom();
   r.write = w[4];
   r.id    = w[3:0];
   return r;
endfunction

// Terminated requests see zero data and the error flag
function automatic ss_pkg::ss_rsp_t expected_rsp(input ss_pkg::ss_req_t r, input bit term);
   ss_pkg::ss_rsp_t e;
   e.id    = r.id;
   e.rdata = term ? '0 : ~r.addr;
   e.err   = term;
   return e;
endfunction

task automatic issue_req(input ss_pkg::ss_req_t r, input bit term);
   @(negedge clk);
   slv_req_valid = 1'b1;
   slv_req       = r;
   #2;
   while (!slv_req_ready) begin
      @(negedge clk);
      #2;
   end
   exp_q.push_back(expected_rsp(r, term));
   @(negedge clk);
   slv_req_valid = 1'b0;
endtask

task automatic wait_idle();
   while (exp_q.size() != 0) begin
      @(negedge clk);
   end
   @(negedge clk);
endtask

task automatic reset_state();
   int e0 = errors;
   repeat (2) @(negedge clk);
   #2;
   check_bit("core_rst_n_o", core_rst_n, 1'b0);
   @(negedge clk);
   arst_n = 1'b1;
   for (int k = 1; k <= `SS_SYNC_STAGES; k++) begin
      @(negedge clk);
      #2;
      check_bit("core_rst_n_o", core_rst_n, k == `SS_SYNC_STAGES);
      check_bit("isolated_o", isolated, 1'b1);
      check_bit("slv_rsp_valid_o", slv_rsp_valid, 1'b0);
      check_bit("mst_req_valid_o", mst_req_valid, 1'b0);
      check_bit("core_fetch_en_o", core_fetch_en, 1'b0);
      check_bit("core_irq_o", core_irq, 1'b0);
   end
   test_done("reset_state", e0);
endtask

task automatic sync_step(input bit use_irq, input bit val);
   @(negedge clk);
   if (use_irq) begin
      irq = val;
   end else begin
      fetch_en = val;
   end
   for (int k = 1; k <= `SS_SYNC_STAGES; k++) begin
      @(negedge clk);
      #2;
      if (use_irq) begin
         check_bit("core_irq_o", core_irq, (k == `SS_SYNC_STAGES) ? val : !val);
      end else begin
         check_bit("core_fetch_en_o", core_fetch_en, (k == `SS_SYNC_STAGES) ? val : !val);
      end
   end
endtask

task automatic sync_inputs();
   int e0 = errors;
   sync_step(1'b0, 1'b1);
   sync_step(1'b0, 1'b0);
   sync_step(1'b1, 1'b1);
   sync_step(1'b1, 1'b0);
   // Test mode bypass of the reset chain
   @(negedge clk);
   test_enable = 1'b1;
   @(negedge clk);
   arst_n = 1'b0;
   #2;
   check_bit("core_rst_n_o", core_rst_n, 1'b0);
   @(negedge clk);
   arst_n = 1'b1;
   #2;
   check_bit("core_rst_n_o", core_rst_n, 1'b1);
   repeat (`SS_SYNC_STAGES) @(negedge clk);
   test_enable = 1'b0;
   #2;
   check_bit("core_rst_n_o", core_rst_n, 1'b1);
   test_done("sync_inputs", e0);
endtask

task automatic isolated_term();
   int e0 = errors;
   no_fwd    = 1'b1;
   stall_rsp = 1'b1;
   check_bit("isolated_o", isolated, 1'b1);
   for (int i = 0; i < 6; i++) begin
      issue_req(random_req(), 1'b1);
   end
   stall_rsp = 1'b0;
   wait_idle();
   no_fwd = 1'b0;
   test_done("isolated_term", e0);
endtask

task automatic forwarding();
   int e0 = errors;
   @(negedge clk);
   isolate = 1'b0;
   for (int k = 1; k <= `SS_SYNC_STAGES + 1; k++) begin
      @(negedge clk);
      #2;
      check_bit("isolated_o", isolated, k <= `SS_SYNC_STAGES);
   end
   stall_req = 1'b1;
   stall_rsp = 1'b1;
   for (int i = 0; i < 20; i++) begin
      issue_req(random_req(), 1'b0);
   end
   stall_req = 1'b0;
   stall_rsp = 1'b0;
   wait_idle();
   test_done("forwarding", e0);
endtask

task automatic pending_limit();
   int              e0 = errors;
   ss_pkg::ss_req_t r;
   hold_rsp = 1'b1;
   for (int i = 0; i < `SS_MAX_PENDING; i++) begin
      issue_req(random_req(), 1'b0);
   end
   r = random_req();
   @(negedge clk);
   slv_req_valid = 1'b1;
   slv_req       = r;
   repeat (10) begin
      #2;
      check_bit("slv_req_ready_o", slv_req_ready, 1'b0);
      @(negedge clk);
   end
   hold_rsp = 1'b0;
   #2;
   while (!slv_req_ready) begin
      @(negedge clk);
      #2;
   end
   exp_q.push_back(expected_rsp(r, 1'b0));
   @(negedge clk);
   slv_req_valid = 1'b0;
   wait_idle();
   test_done("pending_limit", e0);
endtask

task automatic drain();
   int e0 = errors;
   int n = 0;
   hold_rsp = 1'b1;
   for (int i = 0; i < 4; i++) begin
      issue_req(random_req(), 1'b0);
   end
   @(negedge clk);
   isolate = 1'b1;
   repeat (8) begin
      @(negedge clk);
      #2;
      check_bit("isolated_o", isolated, 1'b0);
   end
   hold_rsp = 1'b0;
   wait_idle();
   #2;
   while (!isolated && n < 10) begin
      @(negedge clk);
      #2;
      n++;
   end
   if (!isolated) begin
      $display("Port did not become isolated after the pending responses returned");
      errors++;
   end
   no_fwd = 1'b1;
   for (int i = 0; i < 3; i++) begin
      issue_req(random_req(), 1'b1);
   end
   wait_idle();
   no_fwd = 1'b0;
   test_done("drain", e0);
endtask

`endif

// File: verif/tb_secure_subsystem.sv
// Testbench for the secure subsystem wrapper
// Clock, reset, downstream responder model, response monitor and timeout

`include "ss_cfg.svh"

module tb_secure_subsystem;

   localparam int max_cycles = 2000;

   logic            clk = 1'b0;
   logic            arst_n;
   logic            test_enable;
   logic            fetch_en;
   logic            irq;
   logic            isolate;
   logic            core_rst_n;
   logic            core_fetch_en;
   logic            core_irq;
   logic            isolated;
   logic            slv_req_valid;
   ss_pkg::ss_req_t slv_req;
   logic            slv_req_ready;
   logic            slv_rsp_valid;
   ss_pkg::ss_rsp_t slv_rsp;
   logic            slv_rsp_ready;
   logic            mst_req_valid;
   ss_pkg::ss_req_t mst_req;
   logic            mst_req_ready;
   logic            mst_rsp_valid;
   ss_pkg::ss_rsp_t mst_rsp;
   logic            mst_rsp_ready;

   int              cycle = 0;
   int              errors = 0;
   int              checks = 0;
   bit              hold_rsp = 1'b0;
   bit              stall_req = 1'b0;
   bit              stall_rsp = 1'b0;
   bit              no_fwd = 1'b0;
   ss_pkg::ss_rsp_t exp_q[$];
   ss_pkg::ss_rsp_t resp_q[$];
   int              due_q[$];

   always #4 clk = ~clk;

   secure_subsystem_wrap u_secure_subsystem_wrap (
      .clk_i           ( clk           ),
      .arst_n_i        ( arst_n        ),
      .test_enable_i   ( test_enable   ),
      .fetch_en_i      ( fetch_en      ),
      .irq_i           ( irq           ),
      .isolate_i       ( isolate       ),
      .core_rst_n_o    ( core_rst_n    ),
      .core_fetch_en_o ( core_fetch_en ),
      .core_irq_o      ( core_irq      ),
      .isolated_o      ( isolated      ),
      .slv_req_valid_i ( slv_req_valid ),
      .slv_req_i       ( slv_req       ),
      .slv_req_ready_o ( slv_req_ready ),
      .slv_rsp_valid_o ( slv_rsp_valid ),
      .slv_rsp_o       ( slv_rsp       ),
      .slv_rsp_ready_i ( slv_rsp_ready ),
      .mst_req_valid_o ( mst_req_valid ),
      .mst_req_o       ( mst_req       ),
      .mst_req_ready_i ( mst_req_ready ),
      .mst_rsp_valid_i ( mst_rsp_valid ),
      .mst_rsp_i       ( mst_rsp       ),
      .mst_rsp_ready_o ( mst_rsp_ready )
   );

   bind secure_subsystem_wrap ss_properties u_properties (
      .clk_i           ( clk_i           ),
      .arst_n_i        ( arst_n_i        ),
      .isolated_o      ( isolated_o      ),
      .slv_rsp_valid_o ( slv_rsp_valid_o ),
      .slv_rsp_ready_i ( slv_rsp_ready_i ),
      .slv_rsp_o       ( slv_rsp_o       ),
      .mst_req_valid_o ( mst_req_valid_o ),
      .mst_req_ready_i ( mst_req_ready_i ),
      .mst_req_o       ( mst_req_o       )
   );

   // Downstream responder, drives on the falling edge and samples 2 units later
   initial begin
      ss_pkg::ss_rsp_t item;
      bit              rsp_taken;
      mst_req_ready = 1'b1;
      mst_rsp_valid = 1'b0;
      mst_rsp       = '0;
      rsp_taken     = 1'b0;
      forever begin
         @(negedge clk);
         // Response taken on the last rising edge
         if (rsp_taken) begin
            mst_rsp_valid = 1'b0;
            void'(resp_q.pop_front());
            void'(due_q.pop_front());
            rsp_taken = 1'b0;
         end
         mst_req_ready = !(stall_req && ($urandom_range(1, 0) == 1));
         if (!mst_rsp_valid && resp_q.size() != 0 && !hold_rsp && cycle >= due_q[0]) begin
            mst_rsp       = resp_q[0];
            mst_rsp_valid = 1'b1;
         end
         #2;
         if (arst_n && mst_req_valid && mst_req_ready) begin
            checks++;
            if (mst_req !== slv_req) begin
               $display("ERROR mst_req_o got %h expected %h", mst_req, slv_req);
               errors++;
            end
            item.rdata = ~mst_req.addr;
            item.id    = mst_req.id;
            item.err   = 1'b0;
            resp_q.push_back(item);
            due_q.push_back(cycle + 1 + $urandom_range(3, 0));
         end
         if (arst_n && mst_rsp_valid && mst_rsp_ready) begin
            rsp_taken = 1'b1;
         end
      end
   end

   // Upstream response monitor with random back-pressure, compares in order
   initial begin
      slv_rsp_ready = 1'b1;
      forever begin
         @(negedge clk);
         slv_rsp_ready = !(stall_rsp && ($urandom_range(1, 0) == 1));
         #3;
         if (arst_n && slv_rsp_valid && slv_rsp_ready) begin
            checks++;
            if (exp_q.size() == 0) begin
               $display("Unexpected response on the upstream port, id %h", slv_rsp.id);
               errors++;
            end else begin
               if (slv_rsp !== exp_q[0]) begin
                  $display("ERROR slv_rsp_o got %h expected %h", slv_rsp, exp_q[0]);
                  errors++;
               end
               void'(exp_q.pop_front());
            end
         end
         if (no_fwd && mst_req_valid) begin
            $display("ERROR mst_req_valid_o got %h expected %h", mst_req_valid, 1'b0);
            errors++;
         end
      end
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= max_cycles) begin
         $display("Run stopped, timeout after %0d cycles", cycle);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   `include "tb_secure_subsystem_tests.svh"

   initial begin
      void'($urandom(32'haf5f_6886));
      arst_n        = 1'b0;
      test_enable   = 1'b0;
      fetch_en      = 1'b0;
      irq           = 1'b0;
      isolate       = 1'b1;
      slv_req_valid = 1'b0;
      slv_req       = '0;
      reset_state();
      sync_inputs();
      isolated_term();
      forwarding();
      pending_limit();
      drain();
      repeat (2) @(negedge clk);
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule
